// ==== hw/dma_csr_pkg.sv ====
package dma_csr_pkg;

    // =========================================================================
    // Control port types
    // =========================================================================

    // Every register in the bank is one 32-bit word
    typedef logic [31:0] csr_word_t;

    // Byte address into the 128-byte slave window
    typedef logic [6:0] csr_addr_t;

    // Register index, taken from the byte address shifted right by two.
    // Five bits cover all 32 word slots of the window
    typedef enum logic [4:0] {
        BUFF_HI   = 5'd0,
        BUFF_LO   = 5'd1,
        BUFF_SIZE = 5'd2,
        START     = 5'd3,
        PAUSE     = 5'd4
    } csr_index_e;

    // Access response codes, same encoding as an AXI response field
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } csr_resp_e;

endpackage

// ==== hw/dma_bus_pkg.sv ====
package dma_bus_pkg;

    // =========================================================================
    // AXI master read channel fields
    // =========================================================================

    // Host addresses are full 64-bit PCIe addresses
    localparam int ADDR_WIDTH = 64;

    typedef logic [ADDR_WIDTH-1:0] bus_addr_t;

    // Beats per burst minus one
    typedef logic [7:0] burst_len_t;

    // log2 of the bytes in one beat
    typedef logic [2:0] burst_size_t;

    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } burst_type_e;

    // States of the AR request machine
    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_LOAD,
        REQ_ISSUE
    } req_state_e;

endpackage

// ==== hw/dma_csr_bank.sv ====
module dma_csr_bank (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    csr_write,
    input  dma_csr_pkg::csr_addr_t  csr_waddr,
    input  dma_csr_pkg::csr_word_t  csr_wdata,
    input  logic                    csr_read,
    input  dma_csr_pkg::csr_addr_t  csr_raddr,
    output logic                    csr_wdone,
    output dma_csr_pkg::csr_resp_e  csr_wresp,
    output logic                    csr_rdone,
    output dma_csr_pkg::csr_word_t  csr_rdata,
    output dma_csr_pkg::csr_resp_e  csr_rresp,
    output logic                    fetch_start,
    output dma_bus_pkg::bus_addr_t  buff_base,
    output dma_csr_pkg::csr_word_t  buff_blocks,
    output logic                    dma_paused
);
    import dma_csr_pkg::*;

    // Stored registers
    csr_word_t  reg_buff_hi;
    csr_word_t  reg_buff_lo;
    csr_word_t  reg_buff_size;
    csr_word_t  reg_pause;

    // Word indices of the current accesses
    csr_index_e widx;
    csr_index_e ridx;

    assign widx = csr_index_e'(csr_waddr[6:2]);
    assign ridx = csr_index_e'(csr_raddr[6:2]);

    // The requester sees the buffer description straight from the registers
    assign buff_base   = {reg_buff_hi, reg_buff_lo};
    assign buff_blocks = reg_buff_size;

    // DMA is held off for as long as the countdown has not reached zero
    assign dma_paused = (reg_pause != '0);

    // =========================================================================
    // Write side, the start strobe and the pause countdown
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_buff_hi   <= '0;
            reg_buff_lo   <= '0;
            reg_buff_size <= '0;
            reg_pause     <= '0;
            csr_wdone     <= 1'b0;
            fetch_start   <= 1'b0;
        end else begin
            // Both strobes last exactly one cycle
            csr_wdone   <= csr_write;
            fetch_start <= 1'b0;

            // The pause register runs down by one every cycle until it hits zero
            if (dma_paused) begin
                reg_pause <= reg_pause - 1'b1;
            end

            if (csr_write) begin
                csr_wresp <= OKAY;
                case (widx)
                    BUFF_HI:   reg_buff_hi   <= csr_wdata;
                    BUFF_LO:   reg_buff_lo   <= csr_wdata;
                    BUFF_SIZE: reg_buff_size <= csr_wdata;
                    PAUSE:     reg_pause     <= csr_wdata;   // overrides the decrement
                    START:     fetch_start   <= 1'b1;
                    default:   csr_wresp     <= DECERR;
                endcase
            end
        end
    end

    // =========================================================================
    // Read side
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            csr_rdone <= 1'b0;
        end else begin
            csr_rdone <= csr_read;
        end

        if (csr_read) begin
            csr_rresp <= OKAY;
            case (ridx)
                BUFF_HI:   csr_rdata <= reg_buff_hi;
                BUFF_LO:   csr_rdata <= reg_buff_lo;
                BUFF_SIZE: csr_rdata <= reg_buff_size;
                PAUSE:     csr_rdata <= reg_pause;
                // START is write-only and the remaining slots are unmapped
                default: begin
                    csr_rdata <= '0;
                    csr_rresp <= DECERR;
                end
            endcase
        end
    end

endmodule

// ==== hw/dma_burst_requester.sv ====
module dma_burst_requester #(
    parameter int data_bytes      = 64,
    parameter int beats_per_burst = 32
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        fetch_start,
    input  dma_bus_pkg::bus_addr_t      buff_base,
    input  dma_csr_pkg::csr_word_t      buff_blocks,
    input  logic                        dma_paused,
    input  logic                        arready,
    output logic                        arvalid,
    output dma_bus_pkg::bus_addr_t      araddr,
    output dma_bus_pkg::burst_len_t     arlen,
    output dma_bus_pkg::burst_size_t    arsize,
    output dma_bus_pkg::burst_type_e    arburst,
    output logic                        fetching
);
    import dma_bus_pkg::*;
    import dma_csr_pkg::*;

    // Address step from one burst to the next
    localparam bus_addr_t BURST_BYTES = bus_addr_t'(data_bytes * beats_per_burst);

    req_state_e state;

    // Requests still to be accepted in the current pass, this one included
    csr_word_t  blocks_left;

    // Burst shape never changes
    assign arlen   = burst_len_t'(beats_per_burst - 1);
    assign arsize  = burst_size_t'($clog2(data_bytes));
    assign arburst = INCR;

    // Once started the controller keeps fetching until reset
    assign fetching = (state != REQ_IDLE);

    // =========================================================================
    // AR request machine
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= REQ_IDLE;
            arvalid <= 1'b0;
        end else begin
            case (state)
                // Wait for software to write the start register
                REQ_IDLE: begin
                    if (fetch_start) begin
                        state <= REQ_LOAD;
                    end
                end

                // Latch the buffer description and present the first request
                REQ_LOAD: begin
                    if (!dma_paused) begin
                        araddr      <= buff_base;
                        blocks_left <= buff_blocks;
                        arvalid     <= 1'b1;
                        state       <= REQ_ISSUE;
                    end
                end

                REQ_ISSUE: begin
                    if (arvalid && arready) begin
                        if (blocks_left <= 1) begin
                            // Last block of the pass, go back to the buffer base
                            arvalid <= 1'b0;
                            state   <= REQ_LOAD;
                        end else begin
                            // Step to the next burst and hold it back while paused
                            araddr      <= araddr + BURST_BYTES;
                            blocks_left <= blocks_left - 1'b1;
                            arvalid     <= !dma_paused;
                        end
                    end else if (!arvalid && !dma_paused) begin
                        // Pause has run out so the held address goes out now
                        arvalid <= 1'b1;
                    end
                end

                default: state <= REQ_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/dma_read_stream.sv ====
module dma_read_stream #(
    parameter int data_bytes = 64
) (
    input  logic                      rvalid,
    input  logic [data_bytes*8-1:0]   rdata,
    input  logic                      rlast,
    input  logic                      tready,
    input  logic                      fetching,
    output logic                      rready,
    output logic                      tvalid,
    output logic [data_bytes*8-1:0]   tdata,
    output logic                      burst_done
);

    // =========================================================================
    // Read beats to stream, no storage in between
    // =========================================================================

    // Beats only reach the stream while a fetch is running
    assign tvalid = rvalid && fetching;

    // The sink throttles the read channel.
    // When not fetching every beat is swallowed so the bridge never stalls
    assign rready = tready || !fetching;

    // The last beat of a burst has been handed to the sink
    assign burst_done = rvalid && rready && rlast && fetching;

    // The bridge delivers the bytes little-endian.
    // Put them back in their original order
    for (genvar i = 0; i < data_bytes; i++) begin : g_swap
        assign tdata[i*8 +: 8] = rdata[(data_bytes-1-i)*8 +: 8];
    end

endmodule

// ==== hw/dma_progress_monitor.sv ====
module dma_progress_monitor (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    fetch_start,
    input  dma_csr_pkg::csr_word_t  buff_blocks,
    input  logic                    burst_done,
    input  logic                    tready,
    output logic                    irq_eob,
    output logic                    preload_complete
);
    import dma_csr_pkg::*;

    // Bursts still to arrive before the end of the buffer
    csr_word_t  blocks_to_read;

    // Set by a start and cleared by the first sink stall after it
    logic       preload_armed;

    // =========================================================================
    // End-of-buffer interrupt
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            blocks_to_read <= '0;
            irq_eob        <= 1'b0;
        end else begin
            irq_eob <= 1'b0;

            if (fetch_start) begin
                blocks_to_read <= buff_blocks;
            end else if (burst_done) begin
                if (blocks_to_read == 1) begin
                    // Whole buffer received, start counting the next pass
                    blocks_to_read <= buff_blocks;
                    irq_eob        <= 1'b1;
                end else begin
                    blocks_to_read <= blocks_to_read - 1'b1;
                end
            end
        end
    end

    // =========================================================================
    // Preload complete
    // =========================================================================

    // The first time the sink pushes back after a start, its buffer is full
    always_ff @(posedge clk) begin
        if (!resetn) begin
            preload_armed    <= 1'b0;
            preload_complete <= 1'b0;
        end else begin
            preload_complete <= 1'b0;

            if (fetch_start) begin
                preload_armed <= 1'b1;
            end else if (preload_armed && !tready) begin
                preload_armed    <= 1'b0;
                preload_complete <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/dma_fetch_top.sv ====
module dma_fetch_top #(
    parameter int data_bytes      = 64,
    parameter int beats_per_burst = 32
) (
    input  logic                        clk,
    input  logic                        resetn,
    // Control port
    input  logic                        csr_write,
    input  dma_csr_pkg::csr_addr_t      csr_waddr,
    input  dma_csr_pkg::csr_word_t      csr_wdata,
    output logic                        csr_wdone,
    output dma_csr_pkg::csr_resp_e      csr_wresp,
    input  logic                        csr_read,
    input  dma_csr_pkg::csr_addr_t      csr_raddr,
    output logic                        csr_rdone,
    output dma_csr_pkg::csr_word_t      csr_rdata,
    output dma_csr_pkg::csr_resp_e      csr_rresp,
    // AXI read address channel
    output logic                        arvalid,
    output dma_bus_pkg::bus_addr_t      araddr,
    output dma_bus_pkg::burst_len_t     arlen,
    output dma_bus_pkg::burst_size_t    arsize,
    output dma_bus_pkg::burst_type_e    arburst,
    input  logic                        arready,
    // AXI read data channel
    input  logic                        rvalid,
    input  logic [data_bytes*8-1:0]     rdata,
    input  logic                        rlast,
    output logic                        rready,
    // Stream output
    output logic                        tvalid,
    output logic [data_bytes*8-1:0]     tdata,
    input  logic                        tready,
    // Status strobes
    output logic                        irq_eob,
    output logic                        preload_complete
);
    import dma_bus_pkg::*;
    import dma_csr_pkg::*;

    logic       fetch_start;
    bus_addr_t  buff_base;
    csr_word_t  buff_blocks;
    logic       dma_paused;
    logic       fetching;
    logic       burst_done;

    dma_csr_bank u_csr (
        .clk, .resetn,
        .csr_write, .csr_waddr, .csr_wdata, .csr_read, .csr_raddr,
        .csr_wdone, .csr_wresp, .csr_rdone, .csr_rdata, .csr_rresp,
        .fetch_start, .buff_base, .buff_blocks, .dma_paused
    );

    dma_burst_requester #(
        .data_bytes      (data_bytes),
        .beats_per_burst (beats_per_burst)
    ) u_req (
        .clk, .resetn,
        .fetch_start, .buff_base, .buff_blocks, .dma_paused, .arready,
        .arvalid, .araddr, .arlen, .arsize, .arburst, .fetching
    );

    dma_read_stream #(
        .data_bytes (data_bytes)
    ) u_stream (
        .rvalid, .rdata, .rlast, .tready, .fetching,
        .rready, .tvalid, .tdata, .burst_done
    );

    dma_progress_monitor u_mon (
        .clk, .resetn,
        .fetch_start, .buff_blocks, .burst_done, .tready,
        .irq_eob, .preload_complete
    );

endmodule

// ==== bench/dma_fetch_assert.sv ====
module dma_fetch_assert #(
    parameter int data_bytes      = 8,
    parameter int beats_per_burst = 4
) (
    input logic                     clk,
    input logic                     resetn,
    input logic                     csr_write,
    input dma_csr_pkg::csr_addr_t   csr_waddr,
    input dma_csr_pkg::csr_word_t   csr_wdata,
    input logic                     csr_read,
    input dma_csr_pkg::csr_addr_t   csr_raddr,
    input logic                     csr_wdone,
    input dma_csr_pkg::csr_resp_e   csr_wresp,
    input logic                     csr_rdone,
    input dma_csr_pkg::csr_word_t   csr_rdata,
    input dma_csr_pkg::csr_resp_e   csr_rresp,
    input logic                     arvalid,
    input dma_bus_pkg::bus_addr_t   araddr,
    input dma_bus_pkg::burst_len_t  arlen,
    input dma_bus_pkg::burst_size_t arsize,
    input dma_bus_pkg::burst_type_e arburst,
    input logic                     arready,
    input logic                     rvalid,
    input logic [data_bytes*8-1:0]  rdata,
    input logic                     rlast,
    input logic                     rready,
    input logic                     tvalid,
    input logic [data_bytes*8-1:0]  tdata,
    input logic                     tready,
    input logic                     irq_eob,
    input logic                     preload_complete,
    input logic                     fetch_start,
    input logic                     fetching,
    input logic                     dma_paused
);
    import dma_csr_pkg::*;
    import dma_bus_pkg::*;

    localparam bus_addr_t STEP = bus_addr_t'(data_bytes * beats_per_burst);

    // Running count of failed checks
    int err_count = 0;

    // Shadow copies of what software wrote
    csr_word_t sh_hi, sh_lo, sh_size;
    csr_resp_e exp_wresp, exp_rresp;
    csr_word_t exp_rdata;
    logic      chk_rdata;
    // Expected walk position, burst counter and status strobes
    bus_addr_t exp_addr;
    csr_word_t req_cnt, burst_cnt;
    logic      exp_irq, exp_pre, pre_armed;

    // Reference byte reversal, worked out beat by beat
    function automatic logic [data_bytes*8-1:0] flip(input logic [data_bytes*8-1:0] d);
        logic [data_bytes*8-1:0] r;
        for (int i = 0; i < data_bytes; i++) begin
            r[8*i +: 8] = d[8*(data_bytes-1-i) +: 8];
        end
        return r;
    endfunction

    // ========================================================================
    // Shadow model of the expected behavior
    // ========================================================================
    always @(posedge clk) begin
        if (!resetn) begin
            sh_hi     <= '0;
            sh_lo     <= '0;
            sh_size   <= '0;
            req_cnt   <= '0;
            burst_cnt <= '0;
            exp_irq   <= 1'b0;
            exp_pre   <= 1'b0;
            pre_armed <= 1'b0;
        end else begin
            exp_irq <= 1'b0;
            exp_pre <= 1'b0;
            if (csr_write) begin
                exp_wresp <= (csr_waddr[6:2] <= 5'd4) ? OKAY : DECERR;
                if (csr_waddr[6:2] == 5'd0) sh_hi <= csr_wdata;
                if (csr_waddr[6:2] == 5'd1) sh_lo <= csr_wdata;
                if (csr_waddr[6:2] == 5'd2) sh_size <= csr_wdata;
            end
            if (csr_read) begin
                // Pause counts down, so only its response code is checked
                exp_rresp <= (csr_raddr[6:2] <= 5'd4 && csr_raddr[6:2] != 5'd3)
                             ? OKAY : DECERR;
                chk_rdata <= (csr_raddr[6:2] <= 5'd2);
                exp_rdata <= (csr_raddr[6:2] == 5'd0) ? sh_hi :
                             (csr_raddr[6:2] == 5'd1) ? sh_lo : sh_size;
            end
            if (fetch_start) begin
                exp_addr  <= {sh_hi, sh_lo};
                req_cnt   <= '0;
                burst_cnt <= '0;
                pre_armed <= 1'b1;
            end else begin
                if (arvalid && arready) begin
                    // The pass ends after buff_blocks requests
                    if (req_cnt + 1 >= sh_size) begin
                        exp_addr <= {sh_hi, sh_lo};
                        req_cnt  <= '0;
                    end else begin
                        exp_addr <= exp_addr + STEP;
                        req_cnt  <= req_cnt + 1;
                    end
                end
                if (rvalid && rready && rlast && fetching) begin
                    if (burst_cnt + 1 == sh_size) begin
                        burst_cnt <= '0;
                        exp_irq   <= 1'b1;
                    end else begin
                        burst_cnt <= burst_cnt + 1;
                    end
                end
                if (pre_armed && !tready) begin
                    pre_armed <= 1'b0;
                    exp_pre   <= 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================
    a_wdone: assert property (@(posedge clk) disable iff (!resetn)
        csr_wdone == $past(csr_write))
        else begin
            $error("write done did not follow the write strobe by one cycle");
            err_count++;
        end
    a_rdone: assert property (@(posedge clk) disable iff (!resetn)
        csr_rdone == $past(csr_read))
        else begin
            $error("read done did not follow the read strobe by one cycle");
            err_count++;
        end
    a_wresp: assert property (@(posedge clk) disable iff (!resetn)
        csr_wdone |-> csr_wresp == exp_wresp)
        else begin
            $error("wresp expected %0d actual %0d", exp_wresp, csr_wresp);
            err_count++;
        end
    a_rresp: assert property (@(posedge clk) disable iff (!resetn)
        csr_rdone |-> csr_rresp == exp_rresp && (!chk_rdata || csr_rdata == exp_rdata))
        else begin
            $error("readback expected %0d/%0h actual %0d/%0h",
                   exp_rresp, exp_rdata, csr_rresp, csr_rdata);
            err_count++;
        end
    a_start: assert property (@(posedge clk) disable iff (!resetn)
        csr_write && csr_waddr[6:2] == 5'd3 && !fetching && !dma_paused
        |-> (!arvalid) [*3] ##1 (arvalid && araddr == {sh_hi, sh_lo}))
        else begin
            $error("start expected arvalid at %0h actual %0b at %0h",
                   {sh_hi, sh_lo}, arvalid, araddr);
            err_count++;
        end
    a_walk: assert property (@(posedge clk) disable iff (!resetn)
        arvalid |-> araddr == exp_addr)
        else begin
            $error("walk expected %0h actual %0h", exp_addr, araddr);
            err_count++;
        end
    a_shape: assert property (@(posedge clk) disable iff (!resetn)
        arlen + 1 == beats_per_burst && (1 << arsize) == data_bytes && arburst == INCR)
        else begin
            $error("burst shape expected fixed INCR actual len %0d", arlen);
            err_count++;
        end
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("request dropped or changed while arready was low");
            err_count++;
        end
    a_pause: assert property (@(posedge clk) disable iff (!resetn)
        dma_paused && !arvalid |=> !arvalid)
        else begin
            $error("pause expected arvalid 0 actual 1");
            err_count++;
        end
    a_resume: assert property (@(posedge clk) disable iff (!resetn)
        fetching && !dma_paused && !arvalid |=> arvalid)
        else begin
            $error("requester did not present a request once the pause was over");
            err_count++;
        end
    a_stream: assert property (@(posedge clk) disable iff (!resetn)
        fetching ? (rready == tready && tvalid == rvalid && (!tvalid || tdata == flip(rdata)))
                 : (rready && !tvalid))
        else begin
            $error("stream expected %0h actual %0h", flip(rdata), tdata);
            err_count++;
        end
    a_irq: assert property (@(posedge clk) disable iff (!resetn)
        irq_eob == exp_irq)
        else begin
            $error("irq_eob expected %0b actual %0b", exp_irq, irq_eob);
            err_count++;
        end
    a_pre: assert property (@(posedge clk) disable iff (!resetn)
        preload_complete == exp_pre)
        else begin
            $error("preload expected %0b actual %0b", exp_pre, preload_complete);
            err_count++;
        end

endmodule

bind dma_fetch_top dma_fetch_assert #(
    .data_bytes      (data_bytes),
    .beats_per_burst (beats_per_burst)
) u_chk (.*);

// ==== bench/dma_fetch_tb.sv ====
module dma_fetch_tb;
    import dma_csr_pkg::*;
    import dma_bus_pkg::*;

    localparam int DB = 8;
    localparam int BPB = 4;
    // Lengths of the tests in clock cycles
    localparam int REG_CYCLES = 60;
    localparam int WALK_CYCLES = 200;
    localparam int PAUSE_CYCLES = 120;
    localparam int STREAM_CYCLES = 300;
    localparam int LIMIT = (REG_CYCLES + WALK_CYCLES + PAUSE_CYCLES + STREAM_CYCLES + 200) * 100;

    logic clk, resetn;
    logic csr_write, csr_read, csr_wdone, csr_rdone;
    csr_addr_t csr_waddr, csr_raddr;
    csr_word_t csr_wdata, csr_rdata;
    csr_resp_e csr_wresp, csr_rresp;
    logic arvalid, rready, tvalid;
    logic arready = 1'b0;
    logic rvalid = 1'b0;
    logic rlast = 1'b0;
    logic tready = 1'b1;
    bus_addr_t araddr;
    burst_len_t arlen;
    burst_size_t arsize;
    burst_type_e arburst;
    logic [DB*8-1:0] rdata = '0;
    logic [DB*8-1:0] tdata;
    logic irq_eob, preload_complete;

    // Bus model controls
    logic drain_on, bus_on, stall_on;
    int pending, beat, passed, failed;
    logic [15:0] lfsr = 16'd55074;

    dma_fetch_top #(.data_bytes(DB), .beats_per_burst(BPB)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // One step of the Galois LFSR gives one random bit
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 16'hB400;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
        return v;
    endfunction

    // ========================================================================
    // Memory responder, AR acceptance and sink model
    // ========================================================================
    always @(posedge clk) begin
        if (!resetn) begin
            pending <= 0;
            beat <= 0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            rdata <= '0;
            arready <= 1'b0;
            tready <= 1'b1;
        end else begin
            int p;
            p = pending + ((arvalid && arready) ? 1 : 0);
            // Only beats that belong to an accepted request move the burst along
            if (rvalid && rready && !drain_on && pending > 0) begin
                beat <= rlast ? 0 : beat + 1;
                if (rlast) p = p - 1;
            end
            pending <= p;
            arready <= bus_on ? next_bit() : 1'b0;
            tready <= stall_on ? (next_bit() | next_bit()) : 1'b1;
            if (drain_on) begin
                // Stray data before start must be swallowed
                rvalid <= 1'b1;
                rlast <= next_bit();
                rdata <= {rand_bits(32), rand_bits(32)};
            end else if (!(rvalid && !rready)) begin
                rvalid <= (p > 0);
                rlast <= ((rvalid && rready && !rlast) ? beat + 1 : (rvalid && rready) ? 0 : beat)
                         == BPB - 1;
                rdata <= {rand_bits(32), rand_bits(32)};
            end
        end
    end

    task automatic write_csr(input int idx, input csr_word_t data);
        @(posedge clk);
        csr_write <= 1'b1;
        csr_waddr <= csr_addr_t'(idx << 2);
        csr_wdata <= data;
        @(posedge clk);
        csr_write <= 1'b0;
        @(posedge clk);
    endtask

    task automatic read_csr(input int idx);
        @(posedge clk);
        csr_read <= 1'b1;
        csr_raddr <= csr_addr_t'(idx << 2);
        @(posedge clk);
        csr_read <= 1'b0;
        @(posedge clk);
    endtask

    // One result line per test, from the checks that failed while it ran
    task automatic report(input string name, input int errs_before);
        if (dut.u_chk.err_count == errs_before) begin
            passed++;
            $display("test %-18s passed", name);
        end else begin
            failed++;
            $display("test %-18s failed, %0d assertion errors", name,
                     dut.u_chk.err_count - errs_before);
        end
    endtask

    initial begin
        #(LIMIT);
        $display("Watchdog expired before the tests completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int e;
        resetn = 1'b0;
        csr_write = 1'b0;
        csr_read = 1'b0;
        csr_waddr = '0;
        csr_raddr = '0;
        csr_wdata = '0;
        drain_on = 1'b0;
        bus_on = 1'b0;
        stall_on = 1'b0;
        passed = 0;
        failed = 0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        e = dut.u_chk.err_count;
        drain_on <= 1'b1;
        write_csr(0, rand_bits(32));
        write_csr(1, rand_bits(16) << 16);
        write_csr(2, 32'd3);
        for (int i = 0; i < 6; i++) read_csr(i);
        write_csr(7, rand_bits(32));
        drain_on <= 1'b0;
        repeat (REG_CYCLES - 40) @(posedge clk);
        report("register access", e);

        e = dut.u_chk.err_count;
        bus_on <= 1'b1;
        write_csr(3, 32'd1);
        repeat (WALK_CYCLES) @(posedge clk);
        report("request walk", e);

        e = dut.u_chk.err_count;
        write_csr(4, 32'd25);
        repeat (PAUSE_CYCLES) @(posedge clk);
        report("pause", e);

        e = dut.u_chk.err_count;
        stall_on <= 1'b1;
        repeat (STREAM_CYCLES) @(posedge clk);
        report("stream and strobes", e);

        $display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/dma_csr_pkg.sv
hw/dma_bus_pkg.sv
hw/dma_csr_bank.sv
hw/dma_burst_requester.sv
hw/dma_read_stream.sv
hw/dma_progress_monitor.sv
hw/dma_fetch_top.sv
bench/dma_fetch_assert.sv
bench/dma_fetch_tb.sv

// ==== Bender.yml ====
package:
  name: dma_fetch

sources:
  - files:
      - hw/dma_csr_pkg.sv
      - hw/dma_bus_pkg.sv
      - hw/dma_csr_bank.sv
      - hw/dma_burst_requester.sv
      - hw/dma_read_stream.sv
      - hw/dma_progress_monitor.sv
      - hw/dma_fetch_top.sv
  - target: test
    files:
      - bench/dma_fetch_assert.sv
      - bench/dma_fetch_tb.sv
